// ==== common/rat_consts.svh ====
`ifndef RAT_CONSTS_SVH
`define RAT_CONSTS_SVH

// Rename bundle and port counts.
`define RAT_SLOTS 6
`define RAT_RET_PORTS 4
`define RAT_READ_PORTS 4

`define RAT_ADDR_W 4
`define ROB_ADDR_W 9
`define FN_W 10

// Read indices that select the flag entry instead of a bypass.
`define RAT_IDX_ENTRY 4'hE
`define RAT_IDX_ENTRY_RET 4'hD

`define FN_RESET 10'd9

`endif

// ==== common/rat_pkg.sv ====
`include "rat_consts.svh"

package rat_pkg;

  // Architectural index of a read or rename slot.
  typedef logic [`RAT_ADDR_W-1:0] rat_idx_t;

  typedef logic [`ROB_ADDR_W-1:0] rob_addr_t;

  typedef logic [`FN_W-1:0] funit_t;

  // One bit per rename slot.
  typedef logic [`RAT_SLOTS-1:0] slot_mask_t;

  typedef logic thread_t;

endpackage

// ==== rat_flags/rat_read_capture.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_read_capture (
  input  logic              clk,
  input  logic              rst,
  input  logic              read_clkEn,
  input  rat_pkg::rat_idx_t read_addr [`RAT_READ_PORTS],
  input  rat_pkg::thread_t  read_thread,
  output rat_pkg::rat_idx_t cap_addr [`RAT_READ_PORTS],
  output rat_pkg::thread_t  cap_thread
);

  import rat_pkg::*;

  rat_idx_t addr_q [`RAT_READ_PORTS];
  thread_t  thread_q; // Also steers rename writes.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < `RAT_READ_PORTS; p++)
      begin
        addr_q[p] <= '0;
      end
      thread_q <= '0;
    end
    else if (read_clkEn)
    begin
      for (int p = 0; p < `RAT_READ_PORTS; p++)
      begin
        addr_q[p] <= read_addr[p];
      end
      thread_q <= read_thread;
    end
  end

  assign cap_addr   = addr_q;
  assign cap_thread = thread_q;

endmodule

// ==== rat_flags/rat_slot_bypass.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_slot_bypass #(
  parameter type payload_t = rat_pkg::rob_addr_t
) (
  input  rat_pkg::rat_idx_t idx,
  input  rat_pkg::rat_idx_t rs_index [`RAT_SLOTS],
  input  payload_t          payload [`RAT_SLOTS],
  output payload_t          sel,
  output logic              hit
);

  import rat_pkg::*;

  slot_mask_t match;

  always_comb
  begin
    for (int s = 0; s < `RAT_SLOTS; s++)
    begin
      match[s] = (rs_index[s] == idx);
    end
  end

  // Later slots override earlier ones.
  always_comb
  begin
    sel = '0;
    for (int s = 0; s < `RAT_SLOTS; s++)
    begin
      if (match[s])
      begin
        sel = payload[s];
      end
    end
  end

  assign hit = |match;

endmodule

// ==== rat_flags/rat_read_resolve.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_read_resolve (
  input  rat_pkg::rat_idx_t  cap_addr,
  input  rat_pkg::rat_idx_t  rs_index [`RAT_SLOTS],
  input  rat_pkg::rob_addr_t new_rob [`RAT_SLOTS],
  input  rat_pkg::funit_t    new_fn [`RAT_SLOTS],
  input  rat_pkg::rob_addr_t ent_rob,
  input  rat_pkg::funit_t    ent_fn,
  input  logic               ent_retired,
  output rat_pkg::rob_addr_t read_data,
  output rat_pkg::funit_t    read_fn,
  output logic               read_retired
);

  import rat_pkg::*;

  rob_addr_t byp_rob;
  funit_t    byp_fn;
  logic      byp_hit;

  rat_slot_bypass #(
    .payload_t (rob_addr_t)
  ) rob_bypass_i (
    .idx      (cap_addr),
    .rs_index (rs_index),
    .payload  (new_rob),
    .sel      (byp_rob),
    .hit      (byp_hit)
  );

  // Same match as above, hit not needed twice.
  rat_slot_bypass #(
    .payload_t (funit_t)
  ) fn_bypass_i (
    .idx      (cap_addr),
    .rs_index (rs_index),
    .payload  (new_fn),
    .sel      (byp_fn),
    .hit      ()
  );

  always_comb
  begin
    read_data    = '0;
    read_fn      = '0;
    read_retired = 1'b0;
    case (cap_addr)
      `RAT_IDX_ENTRY:
      begin
        read_data    = ent_rob;
        read_fn      = ent_fn;
        read_retired = ent_retired;
      end
      `RAT_IDX_ENTRY_RET:
      begin
        read_data    = ent_rob;
        read_fn      = ent_fn;
        read_retired = 1'b1; // Forced retired.
      end
      default:
      begin
        if (byp_hit)
        begin
          read_data = byp_rob; // In-flight rename result.
          read_fn   = byp_fn;
        end
      end
    endcase
  end

endmodule

// ==== rat_flags/rat_flag_entry.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_flag_entry (
  input  logic                      clk,
  input  logic                      rst,
  input  rat_pkg::thread_t          cap_thread,
  input  rat_pkg::rob_addr_t        new_rob [`RAT_SLOTS],
  input  rat_pkg::funit_t           new_fn [`RAT_SLOTS],
  input  logic [`RAT_READ_PORTS-1:0] new_wen,
  input  rat_pkg::rob_addr_t        ret_addr [`RAT_RET_PORTS],
  input  logic                      ret_wen [`RAT_RET_PORTS],
  input  logic                      retire_all,
  input  rat_pkg::thread_t          ret_thread,
  output rat_pkg::rob_addr_t        ent_rob,
  output rat_pkg::funit_t           ent_fn,
  output logic                      ent_retired
);

  import rat_pkg::*;

  localparam int NTHREADS = 2;

  rob_addr_t  rob_q [NTHREADS];
  funit_t     fn_q [NTHREADS];
  logic       retired_q [NTHREADS];

  slot_mask_t wen_slot;
  logic       wr_any;
  rob_addr_t  wr_rob;
  funit_t     wr_fn;
  logic       ret_hit [NTHREADS];

  // Write enables sit on slots 1, 2, 4 and 5.
  always_comb
  begin
    wen_slot = '0;
    for (int p = 0; p < `RAT_READ_PORTS; p++)
    begin
      wen_slot[p + p / 2 + 1] = new_wen[p];
    end
  end

  assign wr_any = |wen_slot;

  always_comb
  begin
    wr_rob = '0;
    wr_fn  = '0;
    for (int s = 0; s < `RAT_SLOTS; s++)
    begin
      if (wen_slot[s])
      begin
        wr_rob = new_rob[s]; // Highest slot wins.
        wr_fn  = new_fn[s];
      end
    end
  end

  always_comb
  begin
    for (int t = 0; t < NTHREADS; t++)
    begin
      ret_hit[t] = 1'b0;
      for (int r = 0; r < `RAT_RET_PORTS; r++)
      begin
        ret_hit[t] = ret_hit[t] | (ret_wen[r] & (ret_addr[r] == rob_q[t]));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int t = 0; t < NTHREADS; t++)
    begin
      if (rst)
      begin
        rob_q[t]     <= '0;
        fn_q[t]      <= `FN_RESET;
        retired_q[t] <= 1'b1;
      end
      else if (wr_any && cap_thread == thread_t'(t))
      begin
        rob_q[t]     <= wr_rob;
        fn_q[t]      <= wr_fn;
        retired_q[t] <= 1'b0; // New producer beats retire.
      end
      else if ((ret_hit[t] || retire_all) && ret_thread == thread_t'(t))
      begin
        retired_q[t] <= 1'b1;
      end
    end
  end

  assign ent_rob     = rob_q[cap_thread];
  assign ent_fn      = fn_q[cap_thread];
  assign ent_retired = retired_q[cap_thread];

endmodule

// ==== verilog/rat_flags.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_flags (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       read_clkEn,
  input  rat_pkg::thread_t           read_thread,
  input  rat_pkg::rat_idx_t          read_addr [`RAT_READ_PORTS],
  input  rat_pkg::rob_addr_t         new_rob [`RAT_SLOTS],
  input  rat_pkg::funit_t            new_fn [`RAT_SLOTS],
  input  rat_pkg::rat_idx_t          rs_index [`RAT_SLOTS],
  input  logic [`RAT_READ_PORTS-1:0] new_wen,
  input  rat_pkg::rob_addr_t         ret_addr [`RAT_RET_PORTS],
  input  logic                       ret_wen [`RAT_RET_PORTS],
  input  logic                       retire_all,
  input  rat_pkg::thread_t           ret_thread,
  output rat_pkg::rob_addr_t         read_data [`RAT_READ_PORTS],
  output rat_pkg::funit_t            read_fn [`RAT_READ_PORTS],
  output logic                       read_retired [`RAT_READ_PORTS]
);

  import rat_pkg::*;

  rat_idx_t  cap_addr [`RAT_READ_PORTS];
  thread_t   cap_thread;
  rob_addr_t ent_rob;
  funit_t    ent_fn;
  logic      ent_retired;

  rat_read_capture read_capture_i (
    .clk         (clk),
    .rst         (rst),
    .read_clkEn  (read_clkEn),
    .read_addr   (read_addr),
    .read_thread (read_thread),
    .cap_addr    (cap_addr),
    .cap_thread  (cap_thread)
  );

  rat_flag_entry flag_entry_i (
    .clk         (clk),
    .rst         (rst),
    .cap_thread  (cap_thread),
    .new_rob     (new_rob),
    .new_fn      (new_fn),
    .new_wen     (new_wen),
    .ret_addr    (ret_addr),
    .ret_wen     (ret_wen),
    .retire_all  (retire_all),
    .ret_thread  (ret_thread),
    .ent_rob     (ent_rob),
    .ent_fn      (ent_fn),
    .ent_retired (ent_retired)
  );

  // Port p serves rename slot 1, 2, 4, 5.
  genvar p;
  generate
    for (p = 0; p < `RAT_READ_PORTS; p++)
    begin : g_read
      rat_read_resolve read_resolve_i (
        .cap_addr     (cap_addr[p]),
        .rs_index     (rs_index),
        .new_rob      (new_rob),
        .new_fn       (new_fn),
        .ent_rob      (ent_rob),
        .ent_fn       (ent_fn),
        .ent_retired  (ent_retired),
        .read_data    (read_data[p]),
        .read_fn      (read_fn[p]),
        .read_retired (read_retired[p])
      );
    end
  endgenerate

endmodule

// ==== verification/rat_flags_asserts.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_flags_asserts (
  input logic               clk,
  input logic               rst,
  input rat_pkg::rat_idx_t  cap_addr [`RAT_READ_PORTS],
  input rat_pkg::rob_addr_t read_data [`RAT_READ_PORTS],
  input rat_pkg::funit_t    read_fn [`RAT_READ_PORTS],
  input logic               read_retired [`RAT_READ_PORTS]
);

  genvar p;
  generate
    for (p = 0; p < `RAT_READ_PORTS; p++)
    begin : g_port
      a_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({read_data[p], read_fn[p], read_retired[p]}))
        else $error("Read port %0d output unknown", p);

      a_forced: assert property (@(posedge clk) disable iff (rst)
        cap_addr[p] == `RAT_IDX_ENTRY_RET |-> read_retired[p])
        else $error("Read port %0d index D without retired", p);

      // Bypassed reads are never retired.
      a_bypass: assert property (@(posedge clk) disable iff (rst)
        (cap_addr[p] != `RAT_IDX_ENTRY && cap_addr[p] != `RAT_IDX_ENTRY_RET)
        |-> !read_retired[p])
        else $error("Read port %0d bypass with retired set", p);
    end
  endgenerate

endmodule

bind rat_flags rat_flags_asserts asserts_i (
  .clk          (clk),
  .rst          (rst),
  .cap_addr     (cap_addr),
  .read_data    (read_data),
  .read_fn      (read_fn),
  .read_retired (read_retired)
);

// ==== verification/rat_flags_tb.sv ====
`timescale 1ns/1ps

`include "rat_consts.svh"

module rat_flags_tb;

  import rat_pkg::*;

  localparam int MAX_LINES = 500;

  logic                       clk;
  logic                       rst;
  logic                       read_clkEn;
  thread_t                    read_thread;
  rat_idx_t                   read_addr [`RAT_READ_PORTS];
  rob_addr_t                  new_rob [`RAT_SLOTS];
  funit_t                     new_fn [`RAT_SLOTS];
  rat_idx_t                   rs_index [`RAT_SLOTS];
  logic [`RAT_READ_PORTS-1:0] new_wen;
  rob_addr_t                  ret_addr [`RAT_RET_PORTS];
  logic                       ret_wen [`RAT_RET_PORTS];
  logic                       retire_all;
  thread_t                    ret_thread;
  rob_addr_t                  read_data [`RAT_READ_PORTS];
  funit_t                     read_fn [`RAT_READ_PORTS];
  logic                       read_retired [`RAT_READ_PORTS];

  int    c [15]; // Control line fields.
  int    w [19]; // Rename bundle line fields.
  int    e [12]; // Expected values, three per port.
  int    errors;
  int    checks;
  int    tests;
  int    test_err;
  int    cur_test;
  string test_name [7];

  rat_flags rat_flags_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    #200000;
    $display("Simulation did not finish within the time limit");
    $display("Regression failed");
    $finish;
  end

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
    end
  endtask

  task automatic clear_bundle();
    for (int i = 0; i < 19; i++)
    begin
      w[i] = 0;
    end
  endtask

  task automatic apply_inputs();
    read_clkEn  = c[2][0];
    read_thread = c[3][0];
    for (int p = 0; p < `RAT_READ_PORTS; p++)
    begin
      read_addr[p] = rat_idx_t'(c[4 + p]);
    end
    new_wen = w[0][`RAT_READ_PORTS-1:0];
    for (int s = 0; s < `RAT_SLOTS; s++)
    begin
      rs_index[s] = rat_idx_t'(w[1 + s]);
      new_rob[s]  = rob_addr_t'(w[7 + s]);
      new_fn[s]   = funit_t'(w[13 + s]);
    end
    for (int r = 0; r < `RAT_RET_PORTS; r++)
    begin
      ret_wen[r] = c[8][r];
      // Idle ports carry random addresses.
      ret_addr[r] = c[8][r] ? rob_addr_t'(c[9 + r]) : rob_addr_t'($urandom);
    end
    retire_all = c[13][0];
    ret_thread = c[14][0];
  endtask

  task automatic check_ports();
    for (int p = 0; p < `RAT_READ_PORTS; p++)
    begin
      checks++;
      assert (read_data[p] == rob_addr_t'(e[3 * p]) && read_fn[p] == funit_t'(e[3 * p + 1])
              && read_retired[p] == e[3 * p + 2][0])
      else
      begin
        $display("CHECK FAILED at %0t: test %0d port %0d got %h/%h/%b expected %h/%h/%b",
                 $time, cur_test, p, read_data[p], read_fn[p], read_retired[p],
                 e[3 * p], e[3 * p + 1], e[3 * p + 2][0]);
        errors++;
        test_err++;
      end
    end
  endtask

  task automatic report_test();
    tests++;
    $display("Test %0d %s: %s", cur_test, test_name[cur_test],
             test_err == 0 ? "ok" : "errors");
  endtask

  task automatic run_record();
    if (c[0] != cur_test)
    begin
      if (cur_test != 0)
      begin
        report_test();
      end
      cur_test = c[0];
      test_err = 0;
    end
    @(posedge clk);
    #1;
    apply_inputs();
    #97; // Just before the next edge.
    if (c[1] != 0)
    begin
      check_ports();
    end
  endtask

  initial
  begin
    int    fd;
    int    n;
    int    line_cnt;
    string line;

    test_name[1] = "reset_values";
    test_name[2] = "rename_write";
    test_name[3] = "retire";
    test_name[4] = "forced_retired";
    test_name[5] = "slot_bypass";
    test_name[6] = "capture_hold";
    errors   = 0;
    checks   = 0;
    tests    = 0;
    cur_test = 0;
    test_err = 0;
    n = $urandom(23);
    for (int i = 0; i < 15; i++)
    begin
      c[i] = 0;
    end
    clear_bundle();
    rst = 1'b1;
    apply_inputs();
    wait_cycles(16);
    #1 rst = 1'b0;

    fd = $fopen("verification/rat_flags_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test data file");
      errors++;
    end
    else
    begin
      line_cnt = 0;
      while (!$feof(fd) && line_cnt < MAX_LINES)
      begin
        line_cnt++;
        n = $fgets(line, fd);
        if (n < 2 || line.getc(0) == "#")
        begin
          continue;
        end
        if (line.getc(0) == "C")
        begin
          clear_bundle();
          n = $sscanf(line, "C %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h",
                      c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8],
                      c[9], c[10], c[11], c[12], c[13], c[14]);
        end
        else if (line.getc(0) == "W")
        begin
          n = $sscanf(line, "W %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8], w[9],
                      w[10], w[11], w[12], w[13], w[14], w[15], w[16], w[17], w[18]);
        end
        else if (line.getc(0) == "E")
        begin
          n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h",
                      e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7], e[8],
                      e[9], e[10], e[11]);
          run_record();
        end
      end
      if (!$feof(fd))
      begin
        $display("Test data file did not end within the line limit");
        errors++;
      end
      $fclose(fd);
      if (cur_test != 0)
      begin
        report_test();
      end
    end

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && checks > 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/rat_flags_testdata.txt ====
# C test check read_clkEn read_thread read_addr0..3 ret_wen ret_addr0..3 retire_all ret_thread
# W new_wen rs_index0..5 new_rob0..5 new_fn0..5 / E per port read_data read_fn read_retired
C 1 0 1 0 E E E E 0 000 000 000 000 0 0
E 000 000 0 000 000 0 000 000 0 000 000 0
C 1 1 1 1 E E E E 0 000 000 000 000 0 0
E 000 009 1 000 009 1 000 009 1 000 009 1
C 1 1 1 0 D D D D 0 000 000 000 000 0 0
E 000 009 1 000 009 1 000 009 1 000 009 1
C 2 0 1 0 E E E E 0 000 000 000 000 0 0
W 7 0 0 0 0 0 0 0AA 011 022 0BB 044 055 1AA 101 102 1BB 104 105
E 000 000 0 000 000 0 000 000 0 000 000 0
C 2 1 1 1 E E E E 0 000 000 000 000 0 0
E 044 104 0 044 104 0 044 104 0 044 104 0
C 2 1 1 0 E E E E 0 000 000 000 000 0 0
E 000 009 1 000 009 1 000 009 1 000 009 1
C 3 1 1 0 E E E E 2 000 033 000 000 0 0
E 044 104 0 044 104 0 044 104 0 044 104 0
C 3 1 1 0 E E E E 4 000 000 044 000 0 1
E 044 104 0 044 104 0 044 104 0 044 104 0
C 3 1 1 0 E E E E 8 000 000 000 044 0 0
E 044 104 0 044 104 0 044 104 0 044 104 0
C 3 1 1 1 E E E E 0 000 000 000 000 0 0
E 044 104 1 044 104 1 044 104 1 044 104 1
C 3 1 1 1 E E E E 0 000 000 000 000 0 0
W 8 0 0 0 0 0 0 000 000 000 000 000 1F0 000 000 000 000 000 3FF
E 000 009 1 000 009 1 000 009 1 000 009 1
C 3 1 1 1 E E E E 0 000 000 000 000 1 1
E 1F0 3FF 0 1F0 3FF 0 1F0 3FF 0 1F0 3FF 0
C 3 1 1 1 E E E E 0 000 000 000 000 1 1
W 1 0 0 0 0 0 0 000 0C3 000 000 000 000 000 033 000 000 000 000
E 1F0 3FF 1 1F0 3FF 1 1F0 3FF 1 1F0 3FF 1
C 3 1 1 1 E E E E 0 000 000 000 000 0 0
E 0C3 033 0 0C3 033 0 0C3 033 0 0C3 033 0
C 4 0 1 1 D D D D 0 000 000 000 000 0 0
E 000 000 0 000 000 0 000 000 0 000 000 0
C 4 1 1 1 3 5 7 E 0 000 000 000 000 0 0
E 0C3 033 1 0C3 033 1 0C3 033 1 0C3 033 1
C 5 1 1 1 0 0 0 0 0 000 000 000 000 0 0
W 0 3 5 3 5 9 5 100 101 102 103 104 105 200 201 202 203 204 205
E 102 202 0 105 205 0 000 000 0 0C3 033 0
C 6 1 0 0 E E E E 0 000 000 000 000 0 0
E 000 000 0 000 000 0 000 000 0 000 000 0
C 6 1 0 0 D D D D 0 000 000 000 000 0 0
W 0 0 0 0 0 0 0 000 000 000 000 000 0A5 000 000 000 000 000 15A
E 0A5 15A 0 0A5 15A 0 0A5 15A 0 0A5 15A 0
C 6 1 1 0 E E E E 0 000 000 000 000 0 0
E 000 000 0 000 000 0 000 000 0 000 000 0
C 6 1 1 0 0 0 0 0 0 000 000 000 000 0 0
E 044 104 1 044 104 1 044 104 1 044 104 1

// ==== sources.f ====
+incdir+common
common/rat_pkg.sv
rat_flags/rat_read_capture.sv
rat_flags/rat_slot_bypass.sv
rat_flags/rat_read_resolve.sv
rat_flags/rat_flag_entry.sv
verilog/rat_flags.sv
verification/rat_flags_asserts.sv
verification/rat_flags_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rat_flags regression with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rat_flags_tb -f sources.f \
  -o sim_rat_flags > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_rat_flags > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
